/* logic/ctl_pkg.sv */
// wide controller types
package ctl_pkg;

    localparam int PC_WIDTH    = 16;
    localparam int INSTR_BYTES = 6;

    // horizontal instruction from byte 5 down to byte 0
    typedef struct packed {
        logic [4:0] alu_op;
        logic [4:0] targ_dev;
        logic [3:0] abus_dev;
        logic [3:0] bbus_dev;
        logic [4:0] reserved;
        logic       amode;
        logic [7:0] addr_hi;
        logic [7:0] addr_lo;
        logic [7:0] immed8;
    } instr_t;

    // decoded control word with active low selects
    typedef struct packed {
        logic [4:0]  alu_op;
        logic [7:0]  immed8;
        logic [15:0] direct_address;
        logic        addrmode_register_n;
        logic        addrmode_direct_n;
        logic [15:0] adev_sel_n;
        logic [15:0] bdev_sel_n;
        logic [31:0] tdev_sel_n;
    } ctl_word_t;

    // wishbone classic read bundles
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic [PC_WIDTH-1:0] adr;
    } wb_req_t;

    typedef struct packed {
        logic       ack;
        logic [7:0] dat;
    } wb_rsp_t;

endpackage

/* logic/fetch_unit.sv */
// instruction fetch unit
`timescale 1ns/100ps

module fetch_unit (
    input  logic               clk,
    input  logic               arst_n,
    output ctl_pkg::wb_req_t   wb_req,
    input  ctl_pkg::wb_rsp_t   wb_rsp,
    output logic               push,
    output ctl_pkg::instr_t    push_instr,
    input  logic               full
);

    localparam int ASM_WIDTH = 8 * ctl_pkg::INSTR_BYTES;

    typedef enum logic {
        st_idle,
        st_req
    } state_t;

    state_t                       state;
    logic [ctl_pkg::PC_WIDTH-1:0] pc;
    logic [2:0]                   byte_idx;
    logic [ASM_WIDTH-1:0]         asm_q;
    logic [ASM_WIDTH-1:0]         asm_d;
    logic                         ack_beat;
    logic                         last_byte;

    assign ack_beat  = (state == st_req) && wb_rsp.ack;
    assign last_byte = (byte_idx == 3'(ctl_pkg::INSTR_BYTES - 1));

    // address stays put for the whole bus cycle
    always_comb begin
        wb_req.cyc = (state == st_req);
        wb_req.stb = (state == st_req);
        wb_req.adr = pc;
    end

    // drop the incoming byte into its lane
    always_comb begin
        asm_d = asm_q;
        for (int k = 0; k < ctl_pkg::INSTR_BYTES; k++) begin
            if (byte_idx == 3'(k)) begin
                asm_d[8*k +: 8] = wb_rsp.dat;
            end
        end
    end

    // sixth byte completes the word at the same edge
    assign push       = ack_beat && last_byte;
    assign push_instr = ctl_pkg::instr_t'(asm_d);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= st_idle;
            pc       <= '0;
            byte_idx <= '0;
        end else begin
            case (state)
                st_idle: begin
                    // only hold off at an instruction boundary
                    if (byte_idx != 3'd0 || !full) begin
                        state <= st_req;
                    end
                end
                st_req: begin
                    if (wb_rsp.ack) begin
                        state <= st_idle;
                        pc    <= pc + 1'b1;
                        if (last_byte) begin
                            byte_idx <= '0;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ack_beat) begin
            asm_q <= asm_d;
        end
    end

endmodule

/* logic/instr_queue.sv */
// instruction queue
`timescale 1ns/100ps

module instr_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            push,
    input  ctl_pkg::instr_t push_instr,
    output logic            full,
    input  logic            pop,
    output ctl_pkg::instr_t pop_instr,
    output logic            empty
);

    localparam int AW = $clog2(QUEUE_DEPTH);

    ctl_pkg::instr_t mem [QUEUE_DEPTH];

    // extra msb is the wrap bit
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        do_push;
    logic        do_pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // head entry is read combinationally
    assign pop_instr = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= push_instr;
        end
    end

endmodule

/* logic/select_decoder.sv */
// device select decoder
`timescale 1ns/100ps

module select_decoder (
    input  logic               clk,
    input  logic               arst_n,
    output logic               pop,
    input  ctl_pkg::instr_t    pop_instr,
    input  logic               empty,
    output ctl_pkg::ctl_word_t ctl,
    output logic               ctl_valid,
    input  logic               ctl_ready
);

    // idle word with nothing selected
    localparam ctl_pkg::ctl_word_t CTL_IDLE = '{
        alu_op:              5'd0,
        immed8:              8'd0,
        direct_address:      16'd0,
        addrmode_register_n: 1'b1,
        addrmode_direct_n:   1'b1,
        adev_sel_n:          '1,
        bdev_sel_n:          '1,
        tdev_sel_n:          '1
    };

    ctl_pkg::ctl_word_t ctl_d;
    logic [3:0]         targ_blk_n;
    logic               load;

    // 3 to 8 line demux with active low enable and outputs
    function automatic logic [7:0] demux8_n(input logic en_n, input logic [2:0] sel);
        logic [7:0] y;
        y = '1;
        if (!en_n) begin
            y[sel] = 1'b0;
        end
        return y;
    endfunction

    // 2 to 4 block select
    function automatic logic [3:0] demux4_n(input logic [1:0] sel);
        logic [3:0] y;
        y      = '1;
        y[sel] = 1'b0;
        return y;
    endfunction

    assign targ_blk_n = demux4_n(pop_instr.targ_dev[4:3]);

    always_comb begin
        ctl_d.alu_op              = pop_instr.alu_op;
        ctl_d.immed8              = pop_instr.immed8;
        ctl_d.direct_address      = {pop_instr.addr_hi, pop_instr.addr_lo};
        // low = register mode
        ctl_d.addrmode_register_n = pop_instr.amode;
        ctl_d.addrmode_direct_n   = ~pop_instr.amode;
        ctl_d.adev_sel_n = {demux8_n(~pop_instr.abus_dev[3], pop_instr.abus_dev[2:0]),
                            demux8_n(pop_instr.abus_dev[3], pop_instr.abus_dev[2:0])};
        ctl_d.bdev_sel_n = {demux8_n(~pop_instr.bbus_dev[3], pop_instr.bbus_dev[2:0]),
                            demux8_n(pop_instr.bbus_dev[3], pop_instr.bbus_dev[2:0])};
        ctl_d.tdev_sel_n = {demux8_n(targ_blk_n[3], pop_instr.targ_dev[2:0]),
                            demux8_n(targ_blk_n[2], pop_instr.targ_dev[2:0]),
                            demux8_n(targ_blk_n[1], pop_instr.targ_dev[2:0]),
                            demux8_n(targ_blk_n[0], pop_instr.targ_dev[2:0])};
    end

    // output slot is free or draining this edge
    assign load = !empty && (!ctl_valid || ctl_ready);
    assign pop  = load;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctl       <= CTL_IDLE;
            ctl_valid <= 1'b0;
        end else if (load) begin
            ctl       <= ctl_d;
            ctl_valid <= 1'b1;
        end else if (ctl_ready) begin
            ctl_valid <= 1'b0;
        end
    end

endmodule

/* logic/wide_controller.sv */
// wide controller top level
`timescale 1ns/100ps

module wide_controller #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic               clk,
    input  logic               arst_n,
    output ctl_pkg::wb_req_t   wb_req,
    input  ctl_pkg::wb_rsp_t   wb_rsp,
    output ctl_pkg::ctl_word_t ctl,
    output logic               ctl_valid,
    input  logic               ctl_ready
);

    logic            push;
    ctl_pkg::instr_t push_instr;
    logic            full;
    logic            pop;
    ctl_pkg::instr_t pop_instr;
    logic            empty;

    fetch_unit i_fetch (
        .clk        (clk),
        .arst_n     (arst_n),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .push       (push),
        .push_instr (push_instr),
        .full       (full)
    );

    instr_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_queue (
        .clk        (clk),
        .arst_n     (arst_n),
        .push       (push),
        .push_instr (push_instr),
        .full       (full),
        .pop        (pop),
        .pop_instr  (pop_instr),
        .empty      (empty)
    );

    select_decoder i_decode (
        .clk        (clk),
        .arst_n     (arst_n),
        .pop        (pop),
        .pop_instr  (pop_instr),
        .empty      (empty),
        .ctl        (ctl),
        .ctl_valid  (ctl_valid),
        .ctl_ready  (ctl_ready)
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the wide controller testbench with verilator

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_wide_controller
BUILD_DIR=obj_dir
LOG=sim.log

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --timescale 1ns/100ps \
    --top-module "$TOP" -Mdir "$BUILD_DIR" -f wide_controller.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
    echo "FAIL: see $LOG"
    exit 1
fi

if [ "$status" -ne 0 ]; then
    echo "FAIL: simulator exited with status $status"
    exit 1
fi

echo "PASS"
exit 0

/* verification/tb_wide_controller.sv */
// wide controller testbench
`timescale 1ns/100ps

module tb_wide_controller;

    localparam int QUEUE_DEPTH  = 4;
    localparam int NUM_WORDS    = 200;
    localparam int STALL_CYCLES = 40;
    localparam int STALL_EVERY  = 60;
    localparam int RESUME_LIMIT = 64;
    localparam int FILL_LIMIT   = 400;
    localparam int RUN_LIMIT    = 20000;
    localparam int FULL_LEAD    = ctl_pkg::INSTR_BYTES * (QUEUE_DEPTH + 1);
    localparam int LEAD_LIMIT   = ctl_pkg::INSTR_BYTES * (QUEUE_DEPTH + 1) + 5;

    logic               clk;
    logic               arst_n;
    ctl_pkg::wb_req_t   wb_req;
    ctl_pkg::wb_rsp_t   wb_rsp;
    ctl_pkg::ctl_word_t ctl;
    logic               ctl_valid;
    logic               ctl_ready;

    logic [15:0]        lfsr;
    logic               in_cycle;
    logic [7:0]         wait_left;
    int                 n_acks;
    int                 n_xfer;
    int                 next_stall;
    logic               cyc_open;
    logic [15:0]        open_adr;
    logic               prev_stalled;
    ctl_pkg::ctl_word_t prev_ctl;

    wide_controller #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .ctl       (ctl),
        .ctl_valid (ctl_valid),
        .ctl_ready (ctl_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_eq(input string name, input logic [127:0] got,
                            input logic [127:0] exp);
        if (got !== exp) begin
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // galois form with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hb400;
        end
        return s >> 1;
    endfunction

    task automatic draw_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[6:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // program memory contents
    function automatic logic [7:0] mem_byte(input logic [15:0] a);
        return a[7:0] * 8'd37 + a[15:8];
    endfunction

    function automatic ctl_pkg::ctl_word_t expected_ctl(input int n);
        logic [47:0]        raw;
        logic [15:0]        base;
        ctl_pkg::instr_t    ins;
        ctl_pkg::ctl_word_t c;
        base = 16'(n * ctl_pkg::INSTR_BYTES);
        for (int k = 0; k < ctl_pkg::INSTR_BYTES; k++) begin
            raw[8*k +: 8] = mem_byte(base + 16'(k));
        end
        ins                   = ctl_pkg::instr_t'(raw);
        c.alu_op              = ins.alu_op;
        c.immed8              = ins.immed8;
        c.direct_address      = {ins.addr_hi, ins.addr_lo};
        c.addrmode_register_n = ins.amode;
        c.addrmode_direct_n   = ~ins.amode;
        c.adev_sel_n          = ~(16'd1 << ins.abus_dev);
        c.bdev_sel_n          = ~(16'd1 << ins.bbus_dev);
        c.tdev_sel_n          = ~(32'd1 << ins.targ_dev);
        return c;
    endfunction

    task automatic compare_ctl(input ctl_pkg::ctl_word_t e);
        check_eq("ctl.alu_op", 128'(ctl.alu_op), 128'(e.alu_op));
        check_eq("ctl.immed8", 128'(ctl.immed8), 128'(e.immed8));
        check_eq("ctl.direct_address", 128'(ctl.direct_address), 128'(e.direct_address));
        check_eq("ctl.addrmode_register_n", 128'(ctl.addrmode_register_n),
                 128'(e.addrmode_register_n));
        check_eq("ctl.addrmode_direct_n", 128'(ctl.addrmode_direct_n),
                 128'(e.addrmode_direct_n));
        check_eq("ctl.adev_sel_n", 128'(ctl.adev_sel_n), 128'(e.adev_sel_n));
        check_eq("ctl.bdev_sel_n", 128'(ctl.bdev_sel_n), 128'(e.bdev_sel_n));
        check_eq("ctl.tdev_sel_n", 128'(ctl.tdev_sel_n), 128'(e.tdev_sel_n));
    endtask

    // slave model inserts 0 to 3 wait states per byte
    task automatic drive_bus;
        if (wb_rsp.ack) begin
            wb_rsp.ack = 1'b0;
            wb_rsp.dat = 8'h00;
        end else if (wb_req.cyc && wb_req.stb) begin
            if (!in_cycle) begin
                in_cycle = 1'b1;
                draw_bits(2, wait_left);
            end
            if (wait_left == 8'd0) begin
                wb_rsp.ack = 1'b1;
                wb_rsp.dat = mem_byte(wb_req.adr);
                in_cycle   = 1'b0;
            end else begin
                wait_left = wait_left - 8'd1;
            end
        end
    endtask

    task automatic step_cycle(input logic ready);
        @(posedge clk);
        #1;
        drive_bus();
        ctl_ready = ready;
    endtask

    // ready low about a quarter of the time
    task automatic step_random;
        logic [7:0] v;
        draw_bits(2, v);
        step_cycle(v[1:0] != 2'd0);
    endtask

    task automatic hold_ready_low;
        int acks_at_end;
        int waited;
        waited = 0;
        // let the queue and the output register fill up
        while (n_acks - ctl_pkg::INSTR_BYTES * n_xfer < FULL_LEAD && waited < FILL_LIMIT) begin
            step_cycle(1'b0);
            waited++;
        end
        if (n_acks - ctl_pkg::INSTR_BYTES * n_xfer < FULL_LEAD) begin
            abort_run("Instruction queue did not fill while ctl_ready was held low");
        end
        repeat (STALL_CYCLES) step_cycle(1'b0);
        acks_at_end = n_acks;
        waited      = 0;
        while (n_acks == acks_at_end && waited < RESUME_LIMIT) begin
            step_random();
            waited++;
        end
        if (n_acks == acks_at_end) begin
            abort_run("Fetching did not resume after ctl_ready came back high");
        end
    endtask

    // outputs are sampled mid cycle
    always @(negedge clk) begin
        int lead;
        if (arst_n) begin
            check_eq("wb_req.stb", 128'(wb_req.stb), 128'(wb_req.stb & wb_req.cyc));
            if (cyc_open) begin
                check_eq("wb_req.cyc", 128'(wb_req.cyc), 128'(1'b1));
                check_eq("wb_req.stb", 128'(wb_req.stb), 128'(1'b1));
                check_eq("wb_req.adr", 128'(wb_req.adr), 128'(open_adr));
            end
            if (n_acks == 0) begin
                check_eq("ctl_valid", 128'(ctl_valid), 128'(1'b0));
                check_eq("ctl.adev_sel_n", 128'(ctl.adev_sel_n), 128'(16'hffff));
                check_eq("ctl.bdev_sel_n", 128'(ctl.bdev_sel_n), 128'(16'hffff));
                check_eq("ctl.tdev_sel_n", 128'(ctl.tdev_sel_n), 128'(32'hffff_ffff));
                check_eq("ctl.addrmode_register_n", 128'(ctl.addrmode_register_n),
                         128'(1'b1));
                check_eq("ctl.addrmode_direct_n", 128'(ctl.addrmode_direct_n), 128'(1'b1));
            end
            if (wb_req.cyc && wb_rsp.ack) begin
                check_eq("wb_req.adr", 128'(wb_req.adr), 128'(16'(n_acks)));
                n_acks = n_acks + 1;
            end
            cyc_open = wb_req.cyc && !wb_rsp.ack;
            open_adr = wb_req.adr;
            if (prev_stalled) begin
                check_eq("ctl_valid", 128'(ctl_valid), 128'(1'b1));
                check_eq("ctl", 128'(ctl), 128'(prev_ctl));
            end
            if (ctl_valid && ctl_ready) begin
                compare_ctl(expected_ctl(n_xfer));
                n_xfer = n_xfer + 1;
            end
            // bytes fetched ahead of the consumer
            lead = n_acks - ctl_pkg::INSTR_BYTES * n_xfer;
            if (lead > LEAD_LIMIT) begin
                abort_run("Fetch ran further ahead of the consumer than the queue allows");
            end
            prev_stalled = ctl_valid && !ctl_ready;
            prev_ctl     = ctl;
        end
    end

    initial begin
        int guard;
        arst_n       = 1'b0;
        ctl_ready    = 1'b0;
        wb_rsp       = '0;
        lfsr         = 16'd75;
        in_cycle     = 1'b0;
        wait_left    = 8'd0;
        n_acks       = 0;
        n_xfer       = 0;
        next_stall   = 40;
        cyc_open     = 1'b0;
        open_adr     = 16'h0000;
        prev_stalled = 1'b0;
        prev_ctl     = '0;
        repeat (5) @(posedge clk);
        #1 arst_n = 1'b1;
        guard = 0;
        while (n_xfer < NUM_WORDS && guard < RUN_LIMIT) begin
            if (n_xfer >= next_stall) begin
                hold_ready_low();
                next_stall = next_stall + STALL_EVERY;
            end else begin
                step_random();
            end
            guard++;
        end
        if (n_xfer < NUM_WORDS) begin
            $display("Timed out after %0d of %0d control words", n_xfer, NUM_WORDS);
            $display("Simulation failed");
            $fatal(1);
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

/* wide_controller.f */
logic/ctl_pkg.sv
logic/fetch_unit.sv
logic/instr_queue.sv
logic/select_decoder.sv
logic/wide_controller.sv
verification/tb_wide_controller.sv
